// ==== Makefile ====
# Verilator simulation of the CP0 testbench

VERILATOR ?= verilator
TOP       ?= cp0_tb
FILELIST  ?= cp0.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_FLAGS ?= +verilator+error+limit+1000

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)
	$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1; rc=$$?; cat $(LOG); \
	if [ $$rc -ne 0 ] || grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cp0.f ====
+incdir+design
design/cp0_pkg.sv
design/cp0_ifc.sv
design/cp0_timer.sv
design/cp0_exc_regs.sv
design/cp0_read_mux.sv
design/cp0_top.sv
sim/cp0_checker.sv
sim/cp0_tb.sv

// ==== design/cp0_defines.svh ====
`ifndef CP0_DEFINES_SVH
`define CP0_DEFINES_SVH

// cp0 register numbers
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15
`define CP0_REG_CONFIG   5'd16

// exception type word from the pipeline
`define EXC_T_INT  32'h0000_0001
`define EXC_T_ADEL 32'h0000_0004
`define EXC_T_ADES 32'h0000_0005
`define EXC_T_SYS  32'h0000_0008
`define EXC_T_BP   32'h0000_0009
`define EXC_T_RI   32'h0000_000a
`define EXC_T_OV   32'h0000_000c
`define EXC_T_TR   32'h0000_000d
`define EXC_T_ERET 32'h0000_000e

// cause.exccode values
`define EXCCODE_INT  5'h00
`define EXCCODE_ADEL 5'h04
`define EXCCODE_ADES 5'h05
`define EXCCODE_SYS  5'h08
`define EXCCODE_BP   5'h09
`define EXCCODE_RI   5'h0a
`define EXCCODE_OV   5'h0c
`define EXCCODE_TR   5'h0d

`define STATUS_RESET  32'h1000_0000
`define PRID_VALUE    32'h0000_4220
`define CONFIG0_VALUE 32'h8000_0082
`define CONFIG1_VALUE 32'h0021_1080

`define STATUS_EXL_BIT 1
`define CAUSE_BD_BIT   31
`define CAUSE_IP_MSB   15
`define CAUSE_IP_LSB   10
`define CAUSE_EXC_MSB  6
`define CAUSE_EXC_LSB  2
`define CAUSE_WMASK    32'h00c0_0300 // bits 23, 22, 9:8

`endif

// ==== design/cp0_exc_regs.sv ====
`default_nettype none

`include "cp0_defines.svh"

module cp0_exc_regs (
    input  wire logic             clk,
    input  wire logic             rst,
    cp0_wr_if.dst                 wr,
    cp0_exc_if.dst                exc,
    input  wire cp0_pkg::hw_int_t int_i,
    output cp0_pkg::word_t        status_o,
    output cp0_pkg::word_t        cause_o,
    output cp0_pkg::word_t        epc_o,
    output cp0_pkg::word_t        badvaddr_o
);

    cp0_pkg::word_t     status_q;
    cp0_pkg::word_t     cause_q;
    cp0_pkg::word_t     epc_q;
    cp0_pkg::word_t     badvaddr_q;

    cp0_pkg::exc_code_t exc_code;
    logic               exc_valid;  // entry, eret excluded
    logic               is_eret;
    logic               bad_cap;    // address error carries a vaddr
    logic               int_exc;    // epc taken regardless of exl
    logic               epc_upd;
    cp0_pkg::word_t     epc_next;
    logic               wr_ok;

    assign wr_ok = wr.we && (wr.sel == 3'd0);

    // exception type decode
    always_comb begin
        exc_valid = 1'b1;
        is_eret   = 1'b0;
        bad_cap   = 1'b0;
        int_exc   = 1'b0;
        exc_code  = `EXCCODE_INT;
        case (exc.exc_type)
            `EXC_T_INT: begin
                int_exc = 1'b1;
            end
            `EXC_T_ADEL: begin
                exc_code = `EXCCODE_ADEL;
                bad_cap  = 1'b1;
            end
            `EXC_T_ADES: begin
                exc_code = `EXCCODE_ADES;
                bad_cap  = 1'b1;
            end
            `EXC_T_SYS:  exc_code = `EXCCODE_SYS;
            `EXC_T_BP:   exc_code = `EXCCODE_BP;
            `EXC_T_RI:   exc_code = `EXCCODE_RI;
            `EXC_T_OV:   exc_code = `EXCCODE_OV;
            `EXC_T_TR:   exc_code = `EXCCODE_TR;
            `EXC_T_ERET: begin
                exc_valid = 1'b0;
                is_eret   = 1'b1;
            end
            default: begin
                exc_valid = 1'b0; // no exception
            end
        endcase
    end

    // nested exceptions keep the first epc, interrupts always take it
    assign epc_upd  = exc_valid && (!status_q[`STATUS_EXL_BIT] || int_exc);
    assign epc_next = exc.in_delayslot ? (exc.pc - 32'd4) : exc.pc;

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q   <= `STATUS_RESET;
            cause_q    <= '0;
            epc_q      <= '0;
            badvaddr_q <= '0;
        end else begin
            if (wr_ok) begin
                case (wr.num)
                    `CP0_REG_STATUS:   status_q   <= wr.wdata;
                    `CP0_REG_EPC:      epc_q      <= wr.wdata;
                    `CP0_REG_BADVADDR: badvaddr_q <= wr.wdata;
                    `CP0_REG_CAUSE: begin
                        cause_q <= (cause_q & ~`CAUSE_WMASK) | (wr.wdata & `CAUSE_WMASK);
                    end
                    default: ;
                endcase
            end

            cause_q[`CAUSE_IP_MSB:`CAUSE_IP_LSB] <= int_i;

            // exception fields land after the sw write so they win
            if (exc_valid) begin
                status_q[`STATUS_EXL_BIT]              <= 1'b1;
                cause_q[`CAUSE_EXC_MSB:`CAUSE_EXC_LSB] <= exc_code;
                if (epc_upd) begin
                    epc_q                  <= epc_next;
                    cause_q[`CAUSE_BD_BIT] <= exc.in_delayslot;
                end
                if (bad_cap) begin
                    badvaddr_q <= exc.bad_vaddr;
                end
            end else if (is_eret) begin
                status_q[`STATUS_EXL_BIT] <= 1'b0;
            end
        end
    end

    assign status_o   = status_q;
    assign cause_o    = cause_q;
    assign epc_o      = epc_q;
    assign badvaddr_o = badvaddr_q;

endmodule

`default_nettype wire

// ==== design/cp0_ifc.sv ====
`default_nettype none

// software write from the core, one-cycle strobe
interface cp0_wr_if;
    logic             we;
    cp0_pkg::reg_num_t num;
    cp0_pkg::reg_sel_t sel;
    cp0_pkg::word_t    wdata;

    modport src (
        output we,
        output num,
        output sel,
        output wdata
    );

    modport dst (
        input we,
        input num,
        input sel,
        input wdata
    );
endinterface

// exception report, sampled every cycle
interface cp0_exc_if;
    cp0_pkg::exc_type_t exc_type;
    cp0_pkg::word_t     pc;
    cp0_pkg::word_t     bad_vaddr;
    logic               in_delayslot;

    modport src (
        output exc_type,
        output pc,
        output bad_vaddr,
        output in_delayslot
    );

    modport dst (
        input exc_type,
        input pc,
        input bad_vaddr,
        input in_delayslot
    );
endinterface

`default_nettype wire

// ==== design/cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

    // data and address words
    typedef logic [31:0] word_t;

    // register addressing
    typedef logic [4:0] reg_num_t;
    typedef logic [2:0] reg_sel_t;

    // exception type as reported by the pipeline, one-hot-ish codes
    typedef logic [31:0] exc_type_t;

    typedef logic [4:0] exc_code_t; // cause[6:2]

    typedef logic [5:0] hw_int_t; // hw interrupt lines

endpackage

`default_nettype wire

// ==== design/cp0_read_mux.sv ====
`default_nettype none

`include "cp0_defines.svh"

module cp0_read_mux (
    input  wire cp0_pkg::reg_num_t raddr_i,
    input  wire cp0_pkg::reg_sel_t rsel_i,
    input  wire cp0_pkg::word_t    count_i,
    input  wire cp0_pkg::word_t    compare_i,
    input  wire cp0_pkg::word_t    status_i,
    input  wire cp0_pkg::word_t    cause_i,
    input  wire cp0_pkg::word_t    epc_i,
    input  wire cp0_pkg::word_t    badvaddr_i,
    output cp0_pkg::word_t         data_o
);

    cp0_pkg::word_t config_word;

    // config has two selects, the rest read as zero
    always_comb begin
        case (rsel_i)
            3'd0:    config_word = `CONFIG0_VALUE;
            3'd1:    config_word = `CONFIG1_VALUE;
            default: config_word = '0;
        endcase
    end

    always_comb begin
        case (raddr_i)
            `CP0_REG_BADVADDR: data_o = badvaddr_i;
            `CP0_REG_COUNT:    data_o = count_i;
            `CP0_REG_COMPARE:  data_o = compare_i;
            `CP0_REG_STATUS:   data_o = status_i;
            `CP0_REG_CAUSE:    data_o = cause_i;
            `CP0_REG_EPC:      data_o = epc_i;
            `CP0_REG_PRID:     data_o = `PRID_VALUE;
            `CP0_REG_CONFIG:   data_o = config_word;
            default:           data_o = '0; // unimplemented
        endcase
    end

endmodule

`default_nettype wire

// ==== design/cp0_timer.sv ====
`default_nettype none

`include "cp0_defines.svh"

module cp0_timer (
    input  wire logic     clk,
    input  wire logic     rst,
    cp0_wr_if.dst         wr,
    output cp0_pkg::word_t count_o,
    output cp0_pkg::word_t compare_o,
    output logic          timer_int_o
);

    logic           tick;
    cp0_pkg::word_t count_q;
    cp0_pkg::word_t compare_q;
    logic           timer_int_q;
    logic           wr_ok;
    logic           wr_count;
    logic           wr_compare;
    logic           match;

    assign wr_ok      = wr.we && (wr.sel == 3'd0);
    assign wr_count   = wr_ok && (wr.num == `CP0_REG_COUNT);
    assign wr_compare = wr_ok && (wr.num == `CP0_REG_COMPARE);

    // compare of zero never fires
    assign match = (compare_q != 32'd0) && (count_q == compare_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            tick        <= 1'b0;
            count_q     <= '0;
            compare_q   <= '0;
            timer_int_q <= 1'b0;
        end else begin
            tick <= ~tick; // half rate

            if (wr_count) begin
                count_q <= wr.wdata;
            end else if (tick) begin
                count_q <= count_q + 32'd1;
            end

            if (wr_compare) begin
                compare_q <= wr.wdata;
            end

            // compare write acks the interrupt
            if (wr_compare) begin
                timer_int_q <= 1'b0;
            end else if (match) begin
                timer_int_q <= 1'b1;
            end
        end
    end

    assign count_o     = count_q;
    assign compare_o   = compare_q;
    assign timer_int_o = timer_int_q;

endmodule

`default_nettype wire

// ==== design/cp0_top.sv ====
`default_nettype none

module cp0_top (
    input  wire logic               clk,
    input  wire logic               rst,

    // software access
    input  wire logic               we_i,
    input  wire cp0_pkg::reg_num_t  waddr_i,
    input  wire cp0_pkg::reg_sel_t  wsel_i,
    input  wire cp0_pkg::reg_num_t  raddr_i,
    input  wire cp0_pkg::reg_sel_t  rsel_i,
    input  wire cp0_pkg::word_t     data_i,

    input  wire cp0_pkg::hw_int_t   int_i,

    // exception report from the pipeline
    input  wire cp0_pkg::exc_type_t excepttype_i,
    input  wire cp0_pkg::word_t     pc_i,
    input  wire cp0_pkg::word_t     bad_vaddr_i,
    input  wire logic               in_delayslot_i,

    output cp0_pkg::word_t          data_o,
    output cp0_pkg::word_t          status_o,
    output cp0_pkg::word_t          cause_o,
    output cp0_pkg::word_t          epc_o,
    output logic                    timer_int_o
);

    cp0_pkg::word_t count;
    cp0_pkg::word_t compare;
    cp0_pkg::word_t badvaddr;

    cp0_wr_if  wr_bus ();
    cp0_exc_if exc_bus ();

    assign wr_bus.we    = we_i;
    assign wr_bus.num   = waddr_i;
    assign wr_bus.sel   = wsel_i;
    assign wr_bus.wdata = data_i;

    assign exc_bus.exc_type     = excepttype_i;
    assign exc_bus.pc           = pc_i;
    assign exc_bus.bad_vaddr    = bad_vaddr_i;
    assign exc_bus.in_delayslot = in_delayslot_i;

    cp0_timer u_timer (
        .clk         (clk),
        .rst         (rst),
        .wr          (wr_bus),
        .count_o     (count),
        .compare_o   (compare),
        .timer_int_o (timer_int_o)
    );

    cp0_exc_regs u_exc_regs (
        .clk        (clk),
        .rst        (rst),
        .wr         (wr_bus),
        .exc        (exc_bus),
        .int_i      (int_i),
        .status_o   (status_o),
        .cause_o    (cause_o),
        .epc_o      (epc_o),
        .badvaddr_o (badvaddr)
    );

    cp0_read_mux u_read_mux (
        .raddr_i    (raddr_i),
        .rsel_i     (rsel_i),
        .count_i    (count),
        .compare_i  (compare),
        .status_i   (status_o),
        .cause_i    (cause_o),
        .epc_i      (epc_o),
        .badvaddr_i (badvaddr),
        .data_o     (data_o)
    );

endmodule

`default_nettype wire

// ==== sim/cp0_checker.sv ====
`default_nettype none

`include "cp0_defines.svh"

module cp0_checker (
    input wire logic               clk,
    input wire logic               rst,
    input wire cp0_pkg::exc_type_t exc_type_i,
    input wire cp0_pkg::hw_int_t   int_i,
    input wire cp0_pkg::word_t     status_i,
    input wire cp0_pkg::word_t     cause_i,
    input wire logic               timer_int_i
);
    timeunit 1ns;
    timeprecision 1ps;

    logic        exc_entry;
    logic        exc_eret;
    int unsigned failures = 0;

    assign exc_entry = (exc_type_i == `EXC_T_INT)  || (exc_type_i == `EXC_T_ADEL) ||
                       (exc_type_i == `EXC_T_ADES) || (exc_type_i == `EXC_T_SYS)  ||
                       (exc_type_i == `EXC_T_BP)   || (exc_type_i == `EXC_T_RI)   ||
                       (exc_type_i == `EXC_T_OV)   || (exc_type_i == `EXC_T_TR);
    assign exc_eret  = (exc_type_i == `EXC_T_ERET);

    timer_low_after_reset: assert property (@(posedge clk) rst |=> !timer_int_i)
        else begin
            $error("timer interrupt set right after reset");
            failures++;
        end

    exl_set_on_entry: assert property (@(posedge clk)
        (!rst && exc_entry) |=> status_i[`STATUS_EXL_BIT])
        else begin
            $error("EXL not set after exception entry");
            failures++;
        end

    exl_clear_on_eret: assert property (@(posedge clk)
        (!rst && exc_eret) |=> !status_i[`STATUS_EXL_BIT])
        else begin
            $error("EXL still set after eret");
            failures++;
        end

    // ip field lags the lines by one edge
    ip_follows_int: assert property (@(posedge clk)
        !rst |=> (cause_i[`CAUSE_IP_MSB:`CAUSE_IP_LSB] == $past(int_i)))
        else begin
            $error("cause ip field does not follow int_i");
            failures++;
        end

endmodule

bind cp0_top cp0_checker i_checker (
    .clk         (clk),
    .rst         (rst),
    .exc_type_i  (excepttype_i),
    .int_i       (int_i),
    .status_i    (status_o),
    .cause_i     (cause_o),
    .timer_int_i (timer_int_o)
);

`default_nettype wire

// ==== sim/cp0_tb.sv ====
`default_nettype none

`include "cp0_defines.svh"

module cp0_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMER_TIMEOUT = 64;

    logic               clk;
    logic               rst;
    logic               we;
    cp0_pkg::reg_num_t  waddr;
    cp0_pkg::reg_sel_t  wsel;
    cp0_pkg::reg_num_t  raddr;
    cp0_pkg::reg_sel_t  rsel;
    cp0_pkg::word_t     wdata;
    cp0_pkg::hw_int_t   int_lines;
    cp0_pkg::exc_type_t exc_type;
    cp0_pkg::word_t     pc;
    cp0_pkg::word_t     bad_vaddr;
    logic               in_ds;
    cp0_pkg::word_t     data;
    cp0_pkg::word_t     status;
    cp0_pkg::word_t     cause;
    cp0_pkg::word_t     epc;
    logic               timer_int;

    // reference model
    cp0_pkg::word_t m_status;
    cp0_pkg::word_t m_cause;
    cp0_pkg::word_t m_epc;
    cp0_pkg::word_t m_badvaddr;
    cp0_pkg::word_t m_count;
    cp0_pkg::word_t m_compare;
    logic           m_tick;
    logic           m_timer_int;

    integer seed;
    int     errors;
    int     checks;
    int     waited;

    cp0_top i_dut (
        .clk            (clk),
        .rst            (rst),
        .we_i           (we),
        .waddr_i        (waddr),
        .wsel_i         (wsel),
        .raddr_i        (raddr),
        .rsel_i         (rsel),
        .data_i         (wdata),
        .int_i          (int_lines),
        .excepttype_i   (exc_type),
        .pc_i           (pc),
        .bad_vaddr_i    (bad_vaddr),
        .in_delayslot_i (in_ds),
        .data_o         (data),
        .status_o       (status),
        .cause_o        (cause),
        .epc_o          (epc),
        .timer_int_o    (timer_int)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic cp0_pkg::word_t rand_word();
        rand_word = $random(seed);
    endfunction

    // mostly implemented numbers and sometimes any number
    function automatic cp0_pkg::reg_num_t pick_reg();
        cp0_pkg::word_t rnd;
        rnd = rand_word();
        if (rnd[4:3] == 2'b00) begin
            pick_reg = rnd[20:16];
        end else begin
            case (rnd[10:8])
                3'd0:    pick_reg = `CP0_REG_BADVADDR;
                3'd1:    pick_reg = `CP0_REG_COUNT;
                3'd2:    pick_reg = `CP0_REG_COMPARE;
                3'd3:    pick_reg = `CP0_REG_STATUS;
                3'd4:    pick_reg = `CP0_REG_CAUSE;
                3'd5:    pick_reg = `CP0_REG_EPC;
                3'd6:    pick_reg = `CP0_REG_PRID;
                default: pick_reg = `CP0_REG_CONFIG;
            endcase
        end
    endfunction

    function automatic cp0_pkg::exc_type_t pick_exc();
        cp0_pkg::word_t rnd;
        rnd = rand_word();
        case (rnd[3:0])
            4'd0:       pick_exc = `EXC_T_INT;
            4'd1:       pick_exc = `EXC_T_ADEL;
            4'd2:       pick_exc = `EXC_T_ADES;
            4'd3:       pick_exc = `EXC_T_SYS;
            4'd4:       pick_exc = `EXC_T_BP;
            4'd5:       pick_exc = `EXC_T_RI;
            4'd6:       pick_exc = `EXC_T_OV;
            4'd7:       pick_exc = `EXC_T_TR;
            4'd8, 4'd9: pick_exc = `EXC_T_ERET;
            4'd10:      pick_exc = {8'd0, rnd[31:8]}; // junk type that is nearly always ignored
            default:    pick_exc = 32'd0;
        endcase
    endfunction

    function automatic cp0_pkg::word_t exp_read(cp0_pkg::reg_num_t num, cp0_pkg::reg_sel_t sel);
        case (num)
            `CP0_REG_BADVADDR: exp_read = m_badvaddr;
            `CP0_REG_COUNT:    exp_read = m_count;
            `CP0_REG_COMPARE:  exp_read = m_compare;
            `CP0_REG_STATUS:   exp_read = m_status;
            `CP0_REG_CAUSE:    exp_read = m_cause;
            `CP0_REG_EPC:      exp_read = m_epc;
            `CP0_REG_PRID:     exp_read = `PRID_VALUE;
            `CP0_REG_CONFIG: begin
                if (sel == 3'd0) exp_read = `CONFIG0_VALUE;
                else if (sel == 3'd1) exp_read = `CONFIG1_VALUE;
                else exp_read = 32'd0;
            end
            default:           exp_read = 32'd0;
        endcase
    endfunction

    task automatic check(input string name, input cp0_pkg::word_t got, input cp0_pkg::word_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic model_reset();
        m_status    = `STATUS_RESET;
        m_cause     = 32'd0;
        m_epc       = 32'd0;
        m_badvaddr  = 32'd0;
        m_count     = 32'd0;
        m_compare   = 32'd0;
        m_tick      = 1'b0;
        m_timer_int = 1'b0;
    endtask

    // model one rising edge with the inputs driven in the cycle before it
    task automatic model_edge();
        logic               wr_ok;
        logic               fire;
        logic               old_exl;
        logic               entry;
        logic               is_int;
        logic               take_bad;
        cp0_pkg::exc_code_t code;
        wr_ok   = we && (wsel == 3'd0);
        fire    = (m_compare != 32'd0) && (m_count == m_compare);
        old_exl = m_status[`STATUS_EXL_BIT];

        if (wr_ok && waddr == `CP0_REG_COMPARE) m_timer_int = 1'b0;
        else if (fire) m_timer_int = 1'b1;
        if (wr_ok && waddr == `CP0_REG_COUNT) m_count = wdata;
        else if (m_tick) m_count = m_count + 32'd1;
        if (wr_ok && waddr == `CP0_REG_COMPARE) m_compare = wdata;
        m_tick = ~m_tick;

        if (wr_ok) begin
            case (waddr)
                `CP0_REG_STATUS:   m_status = wdata;
                `CP0_REG_EPC:      m_epc = wdata;
                `CP0_REG_BADVADDR: m_badvaddr = wdata;
                `CP0_REG_CAUSE:    m_cause = (m_cause & ~`CAUSE_WMASK) | (wdata & `CAUSE_WMASK);
                default: ;
            endcase
        end
        m_cause[`CAUSE_IP_MSB:`CAUSE_IP_LSB] = int_lines;

        entry    = 1'b1;
        is_int   = 1'b0;
        take_bad = 1'b0;
        code     = 5'd0;
        case (exc_type)
            `EXC_T_INT: begin
                code   = `EXCCODE_INT;
                is_int = 1'b1;
            end
            `EXC_T_ADEL: begin
                code     = `EXCCODE_ADEL;
                take_bad = 1'b1;
            end
            `EXC_T_ADES: begin
                code     = `EXCCODE_ADES;
                take_bad = 1'b1;
            end
            `EXC_T_SYS:  code = `EXCCODE_SYS;
            `EXC_T_BP:   code = `EXCCODE_BP;
            `EXC_T_RI:   code = `EXCCODE_RI;
            `EXC_T_OV:   code = `EXCCODE_OV;
            `EXC_T_TR:   code = `EXCCODE_TR;
            default:     entry = 1'b0;
        endcase

        if (entry) begin
            m_status[`STATUS_EXL_BIT] = 1'b1;
            m_cause[`CAUSE_EXC_MSB:`CAUSE_EXC_LSB] = code;
            if (!old_exl || is_int) begin
                m_epc = in_ds ? pc - 32'd4 : pc;
                m_cause[`CAUSE_BD_BIT] = in_ds;
            end
            if (take_bad) m_badvaddr = bad_vaddr;
        end else if (exc_type == `EXC_T_ERET) begin
            m_status[`STATUS_EXL_BIT] = 1'b0;
        end
    endtask

    task automatic step();
        @(posedge clk);
        model_edge();
        #1;
    endtask

    task automatic idle_inputs();
        we        = 1'b0;
        waddr     = 5'd0;
        wsel      = 3'd0;
        wdata     = 32'd0;
        exc_type  = 32'd0;
        pc        = 32'd0;
        bad_vaddr = 32'd0;
        in_ds     = 1'b0;
    endtask

    task automatic check_all();
        #1;
        check("status_o", status, m_status);
        check("cause_o", cause, m_cause);
        check("epc_o", epc, m_epc);
        check("timer_int_o", {31'd0, timer_int}, {31'd0, m_timer_int});
        check("data_o", data, exp_read(raddr, rsel));
    endtask

    task automatic read_check(input cp0_pkg::reg_num_t num, input cp0_pkg::reg_sel_t sel);
        raddr = num;
        rsel  = sel;
        #1;
        check($sformatf("data_o[%0d sel %0d]", num, sel), data, exp_read(num, sel));
    endtask

    initial begin : main
        cp0_pkg::word_t rnd;
        seed      = 32'hc51c_5e66;
        errors    = 0;
        checks    = 0;
        rst       = 1'b1;
        raddr     = 5'd0;
        rsel      = 3'd0;
        int_lines = 6'd0;
        idle_inputs();
        model_reset();
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;

        // reset values of the whole map
        for (int n = 0; n < 32; n++) read_check(n[4:0], 3'd0);
        read_check(`CP0_REG_CONFIG, 3'd1);
        read_check(`CP0_REG_CONFIG, 3'd2);
        check_all();

        // software writes each read back after the edge
        for (int i = 0; i < 200; i++) begin
            step();
            rnd   = rand_word();
            we    = 1'b1;
            waddr = pick_reg();
            wsel  = rnd[1:0] != 2'b00 ? 3'd0 : rnd[4:2];
            wdata = rand_word();
            raddr = waddr;
            rsel  = 3'd0;
            check_all();
            step();
            idle_inputs();
            check_all();
        end

        // exception entry and eret with the odd write in the same cycle
        for (int i = 0; i < 300; i++) begin
            step();
            rnd       = rand_word();
            idle_inputs();
            exc_type  = pick_exc();
            pc        = rand_word() & 32'hffff_fffc;
            bad_vaddr = rand_word();
            in_ds     = rnd[0];
            int_lines = rnd[6:1];
            we        = rnd[10:8] == 3'd0;
            waddr     = pick_reg();
            wdata     = rand_word();
            raddr     = `CP0_REG_BADVADDR;
            rsel      = 3'd0;
            check_all();
        end

        // timer rounds
        for (int r = 0; r < 3; r++) begin
            step();
            rnd   = rand_word();
            idle_inputs();
            we    = 1'b1;
            waddr = `CP0_REG_COUNT;
            wdata = {1'b0, rnd[30:0]};
            raddr = `CP0_REG_COUNT;
            check_all();
            step();
            idle_inputs();
            we    = 1'b1;
            waddr = `CP0_REG_COMPARE;
            wdata = m_count + 32'd6;
            check_all();
            waited = 0;
            do begin
                step();
                idle_inputs();
                check_all();
                waited++;
            end while (!timer_int && waited < TIMER_TIMEOUT);
            if (!timer_int) begin
                errors++;
                $display("timer interrupt did not rise within %0d cycles", waited);
            end
            step();
            idle_inputs();
            we    = 1'b1;
            waddr = `CP0_REG_COMPARE;
            wdata = m_count + 32'd200; // ack with a compare far from count
            check_all();
            step();
            idle_inputs();
            check_all();
        end

        // interrupt lines into cause
        raddr = `CP0_REG_CAUSE;
        for (int i = 0; i < 100; i++) begin
            step();
            rnd       = rand_word();
            idle_inputs();
            int_lines = rnd[5:0];
            check_all();
        end

        $display("%0d checks, %0d errors, %0d assertion failures",
                 checks, errors, i_dut.i_checker.failures);
        if (errors == 0 && i_dut.i_checker.failures == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
